//--- bench/fetch_tb.sv
module fetch_tb
    import fetch_pkg::*;
();

    localparam int SEQ_LINES  = 12;     // lines per bank in each sequential pass
    localparam int SEQ_MAX    = 400;    // cycle allowance for one pass
    localparam int RUN_CYCLES = 17 + 2 * SEQ_MAX + 16 * 3 + 200 + 33 + 200;
    localparam int M_NONE = 0, M_RESET = 1, M_HIT = 2, M_TLB = 3;

    logic                              clk, rst, init, resteer, bp_taken;
    logic [LINE_ADDR_W+OFFSET_W-1:0]   init_addr;
    logic [LINE_ADDR_W-1:0]            resteer_fip [2], bp_fip [2];
    logic [TLB_ENTRIES-1:0][VPN_W-1:0] tlb_vpn;
    logic [TLB_ENTRIES-1:0][PFN_W-1:0] tlb_pfn;
    logic [TLB_ENTRIES-1:0]            tlb_valid;

    // per bank arrays with 0 even and 1 odd
    logic                   f_ready [2], f_valid [2], t_miss [2], m_ready [2], m_valid [2];
    logic                   fl_valid [2];
    logic [LINE_W-1:0]      f_line [2], fl_data [2], hold_line [2];
    logic [LINE_ADDR_W-1:0] f_fip [2], mptr [2];
    logic [LINE_ADDR_W-1:0] warm_line;
    logic [PHYS_LINE_W-1:0] m_addr [2], paddr [2], hold_addr [2], req_exp [2], miss_phys [2];
    logic [BANK_LINES-1:0]  mvalid [2];
    logic [TAG_W-1:0]       mtag [2][BANK_LINES];
    bit                     pending [2], hold_f [2], hold_m [2], cf_rand;
    bit                     req_out [2], miss_now [2];
    int                     pdelay [2], xfer [2];
    int                     xfer_limit, ready_pct, mem_pct, mode;
    int                     errors = 0, err_mark = 0, checks = 0;
    int                     hold_f_seen = 0, hold_m_seen = 0, cf_xfer_seen = 0;
    logic [31:0]            lcg;

    fetch_top DUT (
        .clk, .reset_i(rst),
        .init_i(init), .init_addr_i(init_addr), .resteer_i(resteer),
        .resteer_fip_e_i(resteer_fip[0]), .resteer_fip_o_i(resteer_fip[1]),
        .bp_taken_i(bp_taken), .bp_fip_e_i(bp_fip[0]), .bp_fip_o_i(bp_fip[1]),
        .tlb_vpn_i(tlb_vpn), .tlb_pfn_i(tlb_pfn),
        .tlb_valid_i(tlb_valid), .tlb_present_i(tlb_valid),
        .fetch_ready_e_i(f_ready[0]), .fetch_valid_e_o(f_valid[0]),
        .fetch_line_e_o(f_line[0]), .fetch_fip_e_o(f_fip[0]), .tlb_miss_e_o(t_miss[0]),
        .mem_req_ready_e_i(m_ready[0]), .mem_req_valid_e_o(m_valid[0]),
        .mem_req_addr_e_o(m_addr[0]), .fill_valid_e_i(fl_valid[0]), .fill_data_e_i(fl_data[0]),
        .fetch_ready_o_i(f_ready[1]), .fetch_valid_o_o(f_valid[1]),
        .fetch_line_o_o(f_line[1]), .fetch_fip_o_o(f_fip[1]), .tlb_miss_o_o(t_miss[1]),
        .mem_req_ready_o_i(m_ready[1]), .mem_req_valid_o_o(m_valid[1]),
        .mem_req_addr_o_o(m_addr[1]), .fill_valid_o_i(fl_valid[1]), .fill_data_o_i(fl_data[1])
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg >> 8;    // low lcg bits are weak
    endfunction

    // memory contents differ for every physical line
    function automatic logic [LINE_W-1:0] line_hash(input logic [PHYS_LINE_W-1:0] pa);
        logic [31:0] x;
        x = {21'd0, pa} * 32'h9e3779b1 + 32'h7f4a7c15;
        return {x, x ^ 32'h5a5a_a5a5, ~x, x[15:0], x[31:16]};
    endfunction

    function automatic bit translate(input logic [LINE_ADDR_W-1:0] fip,
                                     output logic [PHYS_LINE_W-1:0] phys);
        bit hit;
        hit  = 1'b0;
        phys = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (tlb_valid[i] && tlb_vpn[i] == fip[LINE_ADDR_W-1:PAGE_LINE_W]) begin
                hit  = 1'b1;
                phys = {tlb_pfn[i], fip[PAGE_LINE_W-1:0]};
            end
        end
        return hit;
    endfunction

    function automatic logic [LINE_ADDR_W-1:0] mapped_line();
        logic [31:0] r;
        r = next_rand();
        return {tlb_vpn[r % TLB_ENTRIES], r[15:8]};
    endfunction

    // mostly lines that the sequential test left in the cache
    function automatic logic [LINE_ADDR_W-1:0] cf_target();
        logic [31:0]            r;
        logic [LINE_ADDR_W-1:0] t;
        r = next_rand();
        if (r % 4 == 0) begin
            t = mapped_line();
        end else begin
            t = warm_line + LINE_ADDR_W'(r[15:4] % 24);
        end
        return t;
    endfunction

    task automatic value_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic missing_event(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model runs mid-cycle while everything is settled

    task automatic check_outputs();
        logic [PHYS_LINE_W-1:0] phys;
        bit                     mapped, exp_valid, cf;
        cf = init | resteer | bp_taken;
        for (int b = 0; b < 2; b++) begin
            mapped    = translate(mptr[b], phys);
            exp_valid = mapped && mvalid[b][phys[INDEX_W:1]] &&
                        mtag[b][phys[INDEX_W:1]] == phys[PHYS_LINE_W-1:INDEX_W+1];
            checks++;
            if (f_fip[b] !== mptr[b]) begin
                value_error($sformatf("bank %0d pointer %h, expected %h", b, f_fip[b], mptr[b]));
            end
            if (f_valid[b] !== exp_valid) begin
                value_error($sformatf("bank %0d fetch_valid %b, expected %b",
                                      b, f_valid[b], exp_valid));
            end
            if (exp_valid && f_line[b] !== line_hash(phys)) begin
                value_error($sformatf("bank %0d wrong data for phys line %h", b, phys));
            end
            if (t_miss[b] !== !mapped) begin
                value_error($sformatf("bank %0d tlb_miss %b for pointer %h", b, t_miss[b], mptr[b]));
            end
            if (m_valid[b] !== req_out[b]) begin
                value_error($sformatf("bank %0d mem_req_valid %b, expected %b",
                                      b, m_valid[b], req_out[b]));
            end
            if (req_out[b] && m_addr[b] !== req_exp[b]) begin
                value_error($sformatf("bank %0d request address %h, expected %h",
                                      b, m_addr[b], req_exp[b]));
            end
            if (hold_f[b]) begin
                hold_f_seen++;
                if (f_valid[b] !== 1'b1 || f_line[b] !== hold_line[b]) begin
                    value_error($sformatf("bank %0d fetch line changed while stalled", b));
                end
            end
            if (hold_m[b]) begin
                hold_m_seen++;
                if (m_valid[b] !== 1'b1 || m_addr[b] !== hold_addr[b]) begin
                    value_error($sformatf("bank %0d request changed while stalled", b));
                end
            end
            if (mode == M_RESET && (f_valid[b] || m_valid[b] || f_fip[b] !== LINE_ADDR_W'(b))) begin
                value_error($sformatf("bank %0d not in its reset state", b));
            end
            if (mode == M_HIT && xfer[b] < SEQ_LINES && f_valid[b] !== 1'b1) begin
                value_error($sformatf("bank %0d missed line %h on the second pass", b, mptr[b]));
            end
            if (mode == M_TLB && (!t_miss[b] || f_valid[b] || m_valid[b])) begin
                value_error($sformatf("bank %0d unmapped page not handled as tlb miss", b));
            end
            miss_now[b]  = mapped && !exp_valid;
            miss_phys[b] = phys;
            hold_f[b]    = f_valid[b] && !f_ready[b] && !cf && !fl_valid[b];
            hold_line[b] = f_line[b];
            hold_m[b]    = m_valid[b] && !m_ready[b];
            hold_addr[b] = m_addr[b];
        end
    endtask

    // state the DUT should reach at the coming edge
    task automatic advance_model();
        logic [LINE_ADDR_W-1:0] line;
        logic [LINE_ADDR_W-1:0] target [2];
        bit                     idle;
        line      = init_addr[LINE_ADDR_W+OFFSET_W-1:OFFSET_W];
        target[0] = mptr[0];
        target[1] = mptr[1];
        if (init) begin
            target[line[0]]  = line;            // line to its own bank
            target[!line[0]] = line + 1'b1;
        end else if (resteer) begin
            target = resteer_fip;
        end else if (bp_taken) begin
            target = bp_fip;
        end
        for (int b = 0; b < 2; b++) begin
            idle = !req_out[b] && !pending[b];
            if (fl_valid[b]) begin
                mvalid[b][req_exp[b][INDEX_W:1]] = 1'b1;
                mtag[b][req_exp[b][INDEX_W:1]]   = req_exp[b][PHYS_LINE_W-1:INDEX_W+1];
                pending[b] = 1'b0;
            end
            if (req_out[b] && m_ready[b]) begin
                req_out[b] = 1'b0;
                pending[b] = 1'b1;
                paddr[b]   = m_addr[b];     // responder answers what was asked
                pdelay[b]  = next_rand() % 4;
            end
            if (idle && miss_now[b]) begin
                req_out[b] = 1'b1;
                req_exp[b] = miss_phys[b];
            end
            if (init || resteer || bp_taken) begin
                if (f_valid[b] && f_ready[b]) begin
                    cf_xfer_seen++;
                end
                mptr[b] = {target[b][LINE_ADDR_W-1:1], 1'(b)};
            end else if (f_valid[b] && f_ready[b]) begin
                mptr[b] = mptr[b] + SEQ_STEP;
                xfer[b]++;
            end
        end
    endtask

    task automatic drive_inputs();
        for (int b = 0; b < 2; b++) begin
            f_ready[b]  = (xfer[b] < xfer_limit) && (next_rand() % 100 < ready_pct);
            m_ready[b]  = next_rand() % 100 < mem_pct;
            fl_valid[b] = 1'b0;
            if (pending[b] && pdelay[b] == 0) begin
                fl_valid[b] = 1'b1;
                fl_data[b]  = line_hash(paddr[b]);
            end else if (pending[b]) begin
                pdelay[b]--;
            end
        end
        init     = cf_rand && next_rand() % 4 == 0;
        resteer  = cf_rand && next_rand() % 4 == 0;
        bp_taken = cf_rand && next_rand() % 4 == 0;
        if (cf_rand) begin
            init_addr      = {cf_target(), 4'(next_rand())};
            resteer_fip[0] = cf_target();
            resteer_fip[1] = cf_target();
            bp_fip[0]      = cf_target();
            bp_fip[1]      = cf_target();
        end
    endtask

    task automatic cycle();
        @(negedge clk);
        check_outputs();
        advance_model();
        @(posedge clk);
        #1;
        drive_inputs();
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic run_pass(input logic [31:0] base, input bit second);
        init      = 1'b1;
        init_addr = base;
        cycle();
        xfer[0] = 0;
        xfer[1] = 0;
        mode    = second ? M_HIT : M_NONE;
        while (xfer[0] < SEQ_LINES || xfer[1] < SEQ_LINES) begin
            cycle();
        end
        mode = M_NONE;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        bit               dup;
        logic [VPN_W-1:0] unmapped;
        logic [31:0]      base;
        int               held_f, held_m, held_cf;
        lcg = 32'h3f99cec6;
        clk = 1'b0;
        rst = 1'b1;
        {init, resteer, bp_taken, cf_rand} = '0;
        init_addr = '0;
        warm_line = '0;
        tlb_valid = '0;     // off until the pointers leave X
        for (int b = 0; b < 2; b++) begin
            {f_ready[b], m_ready[b], fl_valid[b], pending[b], hold_f[b], hold_m[b]} = '0;
            {req_out[b], miss_now[b]} = '0;
            {resteer_fip[b], bp_fip[b], fl_data[b]} = '0;
            {req_exp[b], miss_phys[b], paddr[b]} = '0;
            {pdelay[b], xfer[b]} = '0;
            mptr[b]   = LINE_ADDR_W'(b);
            mvalid[b] = '0;
        end
        mode = M_NONE;
        ready_pct  = 70;
        mem_pct    = 60;
        xfer_limit = 1 << 30;
        // unique pages with frames in a fixed permutation
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            do begin
                tlb_vpn[i] = VPN_W'(next_rand());
                dup = 1'b0;
                for (int j = 0; j < i; j++) begin
                    dup |= tlb_vpn[j] == tlb_vpn[i];
                end
            end while (dup);
            tlb_pfn[i] = PFN_W'(i * 3 + 1);
        end
        do begin
            unmapped = VPN_W'(next_rand());
            dup = 1'b0;
            for (int j = 0; j < TLB_ENTRIES; j++) begin
                dup |= tlb_vpn[j] == unmapped;
            end
        end while (dup);
        @(posedge clk);
        #1;
        tlb_valid = '1;
        repeat (15) @(posedge clk);
        #1;
        rst = 1'b0;

        mode = M_RESET;
        cycle();
        mode = M_NONE;
        finish_test("reset");

        base = {mapped_line(), 4'(next_rand())};
        base[OFFSET_W+PAGE_LINE_W-1] = 1'b0;    // both passes stay in the page
        warm_line  = base[LINE_ADDR_W+OFFSET_W-1:OFFSET_W];
        xfer_limit = SEQ_LINES;
        run_pass(base, 1'b0);
        run_pass(base, 1'b1);
        xfer_limit = 1 << 30;
        finish_test("sequential");

        for (int n = 0; n < 16; n++) begin
            init      = 1'b1;
            init_addr = next_rand();
            repeat (3) cycle();
        end
        finish_test("init split");

        held_cf = cf_xfer_seen;
        cf_rand = 1'b1;
        repeat (200) cycle();
        cf_rand = 1'b0;
        if (cf_xfer_seen == held_cf) begin
            missing_event("control flow never met a same-cycle fetch transfer");
        end
        finish_test("priority");

        init           = 1'b0;
        bp_taken       = 1'b0;
        resteer        = 1'b1;
        resteer_fip[0] = {unmapped, 8'(next_rand()) & 8'hfe};
        resteer_fip[1] = resteer_fip[0] + 1'b1;
        mem_pct = 100;      // drain what is still in flight
        repeat (12) cycle();
        mode = M_TLB;
        repeat (20) cycle();
        mode = M_NONE;
        finish_test("tlb miss");

        held_f    = hold_f_seen;
        held_m    = hold_m_seen;
        ready_pct = 20;
        mem_pct   = 20;
        init      = 1'b1;
        init_addr = {mapped_line(), 4'h0};
        init_addr[OFFSET_W+PAGE_LINE_W-1 -: 2] = 2'b00;
        repeat (200) cycle();
        if (hold_f_seen == held_f) begin
            missing_event("fetch_ready low never held a valid line");
        end
        if (hold_m_seen == held_m) begin
            missing_event("mem_req_ready low never held a request");
        end
        finish_test("back-pressure");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #((RUN_CYCLES + 100) * 8);
        $display("watchdog expired, a fetch or fill handshake never completed");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- compile.f
src/fetch_pkg.sv
src/fetch_if.sv
src/cf_select.sv
src/fetch_pointer.sv
src/itlb.sv
src/icache_bank.sv
src/fetch_top.sv
bench/fetch_tb.sv

//--- src/cf_select.sv
module cf_select
    import fetch_pkg::*;
(
    input  logic                            init_i,
    input  logic [LINE_ADDR_W+OFFSET_W-1:0] init_addr_i,
    input  logic                            resteer_i,
    input  logic [LINE_ADDR_W-1:0]          resteer_fip_e_i,
    input  logic [LINE_ADDR_W-1:0]          resteer_fip_o_i,
    input  logic                            bp_taken_i,
    input  logic [LINE_ADDR_W-1:0]          bp_fip_e_i,
    input  logic [LINE_ADDR_W-1:0]          bp_fip_o_i,
    output logic                            cf_load_o,
    output logic [LINE_ADDR_W-1:0]          cf_fip_e_o,
    output logic [LINE_ADDR_W-1:0]          cf_fip_o_o
);

    logic [LINE_ADDR_W-1:0] init_line;
    logic [LINE_ADDR_W-1:0] init_next;
    logic [LINE_ADDR_W-1:0] init_fip_e;
    logic [LINE_ADDR_W-1:0] init_fip_o;

    assign init_line = init_addr_i[LINE_ADDR_W+OFFSET_W-1:OFFSET_W]; // drop byte offset
    assign init_next = init_line + 1'b1;

    // the init line goes to its own bank, the following line to the other one
    always_comb begin
        if (init_line[0]) begin
            init_fip_o = init_line;
            init_fip_e = init_next;
        end else begin
            init_fip_e = init_line;
            init_fip_o = init_next;
        end
    end

    assign cf_load_o = init_i | resteer_i | bp_taken_i;

    // init > resteer > branch
    always_comb begin
        if (init_i) begin
            cf_fip_e_o = init_fip_e;
            cf_fip_o_o = init_fip_o;
        end else if (resteer_i) begin
            cf_fip_e_o = resteer_fip_e_i;
            cf_fip_o_o = resteer_fip_o_i;
        end else begin
            cf_fip_e_o = bp_fip_e_i;    // also don't care when no event
            cf_fip_o_o = bp_fip_o_i;
        end
    end

endmodule

//--- src/fetch_if.sv
interface fetch_if
    import fetch_pkg::*;
();

    fetch_line_u      fip;      // current fetch pointer
    logic [PFN_W-1:0] frame;    // translated frame
    logic             tlb_hit;
    logic             accept;   // fetch handshake done this cycle

    modport ptr (
        output fip,
        input  accept
    );

    modport tlb (
        input  fip,
        output frame,
        output tlb_hit
    );

    modport bank (
        input  fip,
        input  frame,
        input  tlb_hit,
        output accept
    );

endinterface

//--- src/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // address and line geometry

    localparam int LINE_ADDR_W = 28;    // virtual line address, 16-byte lines
    localparam int OFFSET_W    = 4;     // byte offset dropped from a fetch address
    localparam int VPN_W       = 20;
    localparam int PAGE_LINE_W = 8;     // 4 KB page / 16-byte line
    localparam int PFN_W       = 3;
    localparam int PHYS_LINE_W = 11;    // frame over line-in-page
    localparam int LINE_W      = 128;

    ////////////////////////////////////////////////////////////////////////////
    // itlb and bank sizing

    localparam int TLB_ENTRIES = 8;
    localparam int BANK_LINES  = 16;
    localparam int INDEX_W     = 4;
    localparam int TAG_W       = 6;     // phys line minus index and parity
    localparam int SEQ_STEP    = 2;     // each bank sees every other line

    // miss handling states
    localparam int BANK_ST_W = 2;
    localparam logic [BANK_ST_W-1:0] BANK_IDLE = 2'd0;
    localparam logic [BANK_ST_W-1:0] BANK_REQ  = 2'd1;
    localparam logic [BANK_ST_W-1:0] BANK_WAIT = 2'd2;

    // one fetch line address, seen by the itlb and by the bank
    typedef union packed {
        struct packed {
            logic [VPN_W-1:0]       vpn;
            logic [PAGE_LINE_W-1:0] line_in_page;
        } page;
        struct packed {
            logic [LINE_ADDR_W-INDEX_W-2:0] upper;
            logic [INDEX_W-1:0]             index;  // inside line_in_page
            logic                           parity; // even/odd bank select
        } bank;
    } fetch_line_u;

endpackage

//--- src/fetch_pointer.sv
module fetch_pointer
    import fetch_pkg::*;
#(
    parameter bit PARITY = 1'b0
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   cf_load_i,
    input  logic [LINE_ADDR_W-1:0] cf_fip_i,
    fetch_if.ptr                   fif
);

    logic [LINE_ADDR_W-1:0] fip_q;

    ////////////////////////////////////////////////////////////////////////////
    // pointer register
    //
    // control flow beats a same-cycle accept and the low bit is pinned to
    // the bank parity whatever the target says

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fip_q <= LINE_ADDR_W'(PARITY);  // even 0, odd 1
        end else if (cf_load_i) begin
            fip_q <= {cf_fip_i[LINE_ADDR_W-1:1], PARITY};
        end else if (fif.accept) begin
            fip_q <= fip_q + LINE_ADDR_W'(SEQ_STEP);
        end
    end

    assign fif.fip = fip_q;

    // parity seen by the bank never drifts through step or load
    a_parity: assert property (
        @(posedge clk) disable iff (reset_i)
        fif.fip.bank.parity == PARITY
    );

endmodule

//--- src/fetch_top.sv
module fetch_top
    import fetch_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset_i,

    // control flow
    input  logic                            init_i,
    input  logic [LINE_ADDR_W+OFFSET_W-1:0] init_addr_i,
    input  logic                            resteer_i,
    input  logic [LINE_ADDR_W-1:0]          resteer_fip_e_i,
    input  logic [LINE_ADDR_W-1:0]          resteer_fip_o_i,
    input  logic                            bp_taken_i,
    input  logic [LINE_ADDR_W-1:0]          bp_fip_e_i,
    input  logic [LINE_ADDR_W-1:0]          bp_fip_o_i,

    // itlb contents from the core
    input  logic [TLB_ENTRIES-1:0][VPN_W-1:0] tlb_vpn_i,
    input  logic [TLB_ENTRIES-1:0][PFN_W-1:0] tlb_pfn_i,
    input  logic [TLB_ENTRIES-1:0]            tlb_valid_i,
    input  logic [TLB_ENTRIES-1:0]            tlb_present_i,

    // even bank
    input  logic                            fetch_ready_e_i,
    output logic                            fetch_valid_e_o,
    output logic [LINE_W-1:0]               fetch_line_e_o,
    output logic [LINE_ADDR_W-1:0]          fetch_fip_e_o,
    output logic                            tlb_miss_e_o,
    input  logic                            mem_req_ready_e_i,
    output logic                            mem_req_valid_e_o,
    output logic [PHYS_LINE_W-1:0]          mem_req_addr_e_o,
    input  logic                            fill_valid_e_i,
    input  logic [LINE_W-1:0]               fill_data_e_i,

    // odd bank
    input  logic                            fetch_ready_o_i,
    output logic                            fetch_valid_o_o,
    output logic [LINE_W-1:0]               fetch_line_o_o,
    output logic [LINE_ADDR_W-1:0]          fetch_fip_o_o,
    output logic                            tlb_miss_o_o,
    input  logic                            mem_req_ready_o_i,
    output logic                            mem_req_valid_o_o,
    output logic [PHYS_LINE_W-1:0]          mem_req_addr_o_o,
    input  logic                            fill_valid_o_i,
    input  logic [LINE_W-1:0]               fill_data_o_i
);

    logic                   cf_load;
    logic [LINE_ADDR_W-1:0] cf_fip_e;
    logic [LINE_ADDR_W-1:0] cf_fip_o;

    fetch_if if_e ();
    fetch_if if_o ();

    ////////////////////////////////////////////////////////////////////////////
    // control flow, shared by both pointers

    cf_select u_cf (
        .init_i, .init_addr_i,
        .resteer_i, .resteer_fip_e_i, .resteer_fip_o_i,
        .bp_taken_i, .bp_fip_e_i, .bp_fip_o_i,
        .cf_load_o(cf_load), .cf_fip_e_o(cf_fip_e), .cf_fip_o_o(cf_fip_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // even side

    fetch_pointer #(.PARITY(1'b0)) u_ptr_e (
        .clk, .reset_i, .cf_load_i(cf_load), .cf_fip_i(cf_fip_e), .fif(if_e)
    );

    itlb u_tlb_e (.tlb_vpn_i, .tlb_pfn_i, .tlb_valid_i, .tlb_present_i, .fif(if_e));

    icache_bank u_bank_e (
        .clk, .reset_i, .fif(if_e),
        .fetch_ready_i(fetch_ready_e_i), .fetch_valid_o(fetch_valid_e_o),
        .fetch_line_o(fetch_line_e_o), .tlb_miss_o(tlb_miss_e_o),
        .mem_req_ready_i(mem_req_ready_e_i), .mem_req_valid_o(mem_req_valid_e_o),
        .mem_req_addr_o(mem_req_addr_e_o),
        .fill_valid_i(fill_valid_e_i), .fill_data_i(fill_data_e_i)
    );

    ////////////////////////////////////////////////////////////////////////////
    // odd side

    fetch_pointer #(.PARITY(1'b1)) u_ptr_o (
        .clk, .reset_i, .cf_load_i(cf_load), .cf_fip_i(cf_fip_o), .fif(if_o)
    );

    itlb u_tlb_o (.tlb_vpn_i, .tlb_pfn_i, .tlb_valid_i, .tlb_present_i, .fif(if_o));

    icache_bank u_bank_o (
        .clk, .reset_i, .fif(if_o),
        .fetch_ready_i(fetch_ready_o_i), .fetch_valid_o(fetch_valid_o_o),
        .fetch_line_o(fetch_line_o_o), .tlb_miss_o(tlb_miss_o_o),
        .mem_req_ready_i(mem_req_ready_o_i), .mem_req_valid_o(mem_req_valid_o_o),
        .mem_req_addr_o(mem_req_addr_o_o),
        .fill_valid_i(fill_valid_o_i), .fill_data_i(fill_data_o_i)
    );

    assign fetch_fip_e_o = if_e.fip;   // pointers go out with their lines
    assign fetch_fip_o_o = if_o.fip;

endmodule

//--- src/icache_bank.sv
module icache_bank
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    fetch_if.bank                  fif,

    // fetch out
    input  logic                   fetch_ready_i,
    output logic                   fetch_valid_o,
    output logic [LINE_W-1:0]      fetch_line_o,
    output logic                   tlb_miss_o,

    // line request
    input  logic                   mem_req_ready_i,
    output logic                   mem_req_valid_o,
    output logic [PHYS_LINE_W-1:0] mem_req_addr_o,

    // fill, always taken
    input  logic                   fill_valid_i,
    input  logic [LINE_W-1:0]      fill_data_i
);

    logic [TAG_W-1:0]       tag_mem  [BANK_LINES];
    logic [LINE_W-1:0]      data_mem [BANK_LINES];
    logic [BANK_LINES-1:0]  valid_q;

    logic [PHYS_LINE_W-1:0] phys_line;
    logic [INDEX_W-1:0]     index;
    logic [TAG_W-1:0]       tag;
    logic                   line_hit;
    logic                   miss;

    logic [BANK_ST_W-1:0]   state_q;
    logic [PHYS_LINE_W-1:0] req_addr_q;
    logic [INDEX_W-1:0]     fill_index;
    logic [TAG_W-1:0]       fill_tag;
    logic                   fill_write;

    ////////////////////////////////////////////////////////////////////////////
    // lookup

    // index sits inside line-in-page, so virtual and physical agree
    assign phys_line = {fif.frame, fif.fip.page.line_in_page};
    assign index     = fif.fip.bank.index;
    assign tag       = phys_line[PHYS_LINE_W-1:INDEX_W+1];

    assign line_hit = fif.tlb_hit & valid_q[index] & (tag_mem[index] == tag);
    assign miss     = fif.tlb_hit & ~line_hit;  // no request on a tlb miss

    assign fetch_valid_o = line_hit;
    assign fetch_line_o  = data_mem[index];
    assign tlb_miss_o    = ~fif.tlb_hit;
    assign fif.accept    = line_hit & fetch_ready_i;

    ////////////////////////////////////////////////////////////////////////////
    // miss handling, one line in flight

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= BANK_IDLE;
        end else begin
            case (state_q)
                BANK_IDLE: begin
                    if (miss) begin
                        state_q <= BANK_REQ;
                    end
                end
                BANK_REQ: begin
                    if (mem_req_ready_i) begin
                        state_q <= BANK_WAIT;
                    end
                end
                BANK_WAIT: begin
                    if (fill_valid_i) begin
                        state_q <= BANK_IDLE;   // line usable next cycle
                    end
                end
                default: begin
                    state_q <= BANK_IDLE;
                end
            endcase
        end
    end

    // captured when the miss is seen, pointer may move on afterwards
    always_ff @(posedge clk) begin
        if (state_q == BANK_IDLE && miss) begin
            req_addr_q <= phys_line;
        end
    end

    assign mem_req_valid_o = (state_q == BANK_REQ);
    assign mem_req_addr_o  = req_addr_q;

    ////////////////////////////////////////////////////////////////////////////
    // fill into the requested line

    assign fill_index = req_addr_q[INDEX_W:1];
    assign fill_tag   = req_addr_q[PHYS_LINE_W-1:INDEX_W+1];
    assign fill_write = (state_q == BANK_WAIT) & fill_valid_i;

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (fill_write) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // request held until memory takes it
    a_req_hold: assert property (
        @(posedge clk) disable iff (reset_i)
        mem_req_valid_o && !mem_req_ready_i |=>
            mem_req_valid_o && $stable(mem_req_addr_o)
    );

    // memory only answers a request that was sent
    a_fill_in_wait: assert property (
        @(posedge clk) disable iff (reset_i)
        fill_valid_i |-> state_q == BANK_WAIT
    );

endmodule

//--- src/itlb.sv
module itlb
    import fetch_pkg::*;
(
    input  logic [TLB_ENTRIES-1:0][VPN_W-1:0] tlb_vpn_i,
    input  logic [TLB_ENTRIES-1:0][PFN_W-1:0] tlb_pfn_i,
    input  logic [TLB_ENTRIES-1:0]            tlb_valid_i,
    input  logic [TLB_ENTRIES-1:0]            tlb_present_i,
    fetch_if.tlb                              fif
);

    logic [TLB_ENTRIES-1:0] match;
    logic [PFN_W-1:0]       frame;

    ////////////////////////////////////////////////////////////////////////////
    // fully associative compare

    always_comb begin
        match = '0;
        frame = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            // only a valid and present page counts
            match[i] = tlb_valid_i[i] & tlb_present_i[i] &
                       (tlb_vpn_i[i] == fif.fip.page.vpn);
            frame    = frame | (tlb_pfn_i[i] & {PFN_W{match[i]}});
        end
    end

    assign fif.frame   = frame;     // or of matches, one at most
    assign fif.tlb_hit = |match;

    // the core must never map one page twice
    a_one_match: assert final ($onehot0(match));

endmodule
